// ==== flist.f ====
+incdir+include
source/apb_reg_pkg.sv
source/credit_fifo.sv
source/apb_req_bridge.sv
source/reg_bank.sv
source/apb_reg_top.sv
tb/apb_reg_asserts.sv
tb/apb_reg_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; exit status gives the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module apb_reg_tb -o apb_reg_sim \
    && ./obj_dir/apb_reg_sim \
    || exit 1
exit 0

// ==== tb/apb_reg_tb.sv ====
`default_nettype none

`include "apb_reg_macros.svh"

module apb_reg_tb;
    import apb_reg_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int ADDR_W       = `APB_ADDR_W;
    localparam int DATA_W       = `APB_DATA_W;
    localparam int STRB_W       = `APB_STRB_W;
    localparam int STATUS_WORD  = `REG_COUNT;
    localparam int MAX_WORD     = (1 << (ADDR_W - 2)) - 1;

    // ====================
    // Transaction budget
    // ====================
    localparam int RESET_TXN   = `REG_COUNT + 1;
    localparam int MERGE_PAIRS = 24;
    localparam int BURSTS      = 6;
    localparam int BURST_LEN   = 6;
    localparam int OOR_READS   = 6;
    localparam int DROP_WRITES = 8;
    localparam int MIX_TXN     = 400;
    localparam int TOTAL_TXN   = RESET_TXN + 2 * MERGE_PAIRS + BURSTS * (BURST_LEN + 1)
                               + OOR_READS + DROP_WRITES + 1 + MIX_TXN;
    localparam int WATCHDOG_CYCLES = TOTAL_TXN * 30 + RESET_CYCLES;

    logic              apb_if;
    logic              arst_n;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;
    integer            seed;
    logic [DATA_W-1:0] model_regs [`REG_COUNT];
    logic [DATA_W-1:0] model_drops;

    apb_reg_top dut_i (
        .apb_if  (apb_if),
        .arst_n  (arst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    bind credit_fifo apb_reg_asserts #(
        .DEPTH       (DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) asserts_i (
        .apb_if     (apb_if),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_credit (out_credit),
        .count      (count),
        .out_crd    (out_crd)
    );

    initial begin
        apb_if = 1'b0;
        forever #(CLK_PERIOD / 2) apb_if = ~apb_if;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    // ====================
    // Compare tasks
    // ====================
    task automatic check_read(input apb_rsp_t expected, input apb_rsp_t actual);
        if (actual.prdata !== expected.prdata) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: apb_rsp.prdata expected %08h got %08h",
                                    $time, expected.prdata, actual.prdata));
        end
        if (actual.pslverr !== expected.pslverr) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: apb_rsp.pslverr expected %0b got %0b",
                                    $time, expected.pslverr, actual.pslverr));
        end
    endtask

    task automatic check_write_err(input logic expected, input apb_rsp_t actual);
        if (actual.pslverr !== expected) begin
            stop_on_error($sformatf("CHECK FAILED at %0t: apb_rsp.pslverr expected %0b got %0b",
                                    $time, expected, actual.pslverr));
        end
    endtask

    // ====================
    // Reference model
    // ====================
    task automatic model_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                               input logic [STRB_W-1:0] strb);
        int word;
        word = int'(addr[ADDR_W-1:2]);
        if (word < `REG_COUNT) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) begin
                    model_regs[word][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (model_drops != '1) begin
            // Status and unmapped writes are dropped
            model_drops = model_drops + 1'b1;
        end
    endtask

    function automatic apb_rsp_t model_read(input logic [ADDR_W-1:0] addr);
        apb_rsp_t expected;
        int       word;
        expected        = '0;
        expected.pready = 1'b1;
        word            = int'(addr[ADDR_W-1:2]);
        if (word < `REG_COUNT) begin
            expected.prdata = model_regs[word];
        end else if (word == STATUS_WORD) begin
            expected.prdata = model_drops;
        end else begin
            expected.pslverr = 1'b1;
        end
        return expected;
    endfunction

    function automatic logic [ADDR_W-1:0] word_addr(input int word);
        return ADDR_W'(word * 4);
    endfunction

    // ====================
    // APB master
    // ====================
    task automatic apb_transfer(input logic write, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata, input logic [STRB_W-1:0] strb,
                                output apb_rsp_t result);
        @(negedge apb_if);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = strb;
        @(negedge apb_if);
        apb_req.penable = 1'b1;
        // Latency depends on credits and the read path
        do begin
            @(posedge apb_if);
        end while (apb_rsp.pready !== 1'b1);
        result = apb_rsp;
    endtask

    task automatic do_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic [STRB_W-1:0] strb);
        apb_rsp_t result;
        apb_transfer(1'b1, addr, wdata, strb, result);
        check_write_err(1'b0, result);
        model_write(addr, wdata, strb);
    endtask

    task automatic do_read(input logic [ADDR_W-1:0] addr);
        apb_rsp_t result;
        apb_transfer(1'b0, addr, '0, '0, result);
        check_read(model_read(addr), result);
    endtask

    task automatic random_addr(output logic [ADDR_W-1:0] addr);
        int kind;
        int word;
        kind = $unsigned($random(seed)) % 16;
        if (kind < 12) begin
            word = $unsigned($random(seed)) % `REG_COUNT;
        end else if (kind < 14) begin
            word = STATUS_WORD;
        end else begin
            word = STATUS_WORD + 1 + ($unsigned($random(seed)) % (MAX_WORD - STATUS_WORD));
        end
        // Byte offset bits are ignored by the bridge
        addr = ADDR_W'(word * 4 + ($unsigned($random(seed)) % 4));
    endtask

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_on_error("Timeout: the APB transfers did not finish within the time limit");
    end

    initial begin : main_seq
        logic [ADDR_W-1:0] addr;
        int                word;
        apb_req     = '0;
        arst_n      = 1'b0;
        seed        = 32'h63900adf;
        model_drops = '0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge apb_if);
        @(negedge apb_if);
        arst_n = 1'b1;

        // Registers and status start at zero
        for (int w = 0; w <= STATUS_WORD; w++) begin
            do_read(word_addr(w));
        end

        // Byte-strobe merge
        for (int i = 0; i < MERGE_PAIRS; i++) begin
            word = $unsigned($random(seed)) % `REG_COUNT;
            do_write(word_addr(word), $random(seed), STRB_W'($random(seed)));
            do_read(word_addr(word));
        end

        // Posted bursts, last write must win
        for (int i = 0; i < BURSTS; i++) begin
            word = $unsigned($random(seed)) % `REG_COUNT;
            repeat (BURST_LEN) begin
                do_write(word_addr(word), $random(seed), {STRB_W{1'b1}});
            end
            do_read(word_addr(word));
        end

        // Unmapped reads
        for (int i = 0; i < OOR_READS; i++) begin
            word = STATUS_WORD + 1 + ($unsigned($random(seed)) % (MAX_WORD - STATUS_WORD));
            do_read(word_addr(word));
        end

        // Dropped writes, status then unmapped
        for (int i = 0; i < DROP_WRITES; i++) begin
            if (i % 2 == 0) begin
                word = STATUS_WORD;
            end else begin
                word = STATUS_WORD + 1 + ($unsigned($random(seed)) % (MAX_WORD - STATUS_WORD));
            end
            do_write(word_addr(word), $random(seed), STRB_W'($random(seed)));
        end
        do_read(word_addr(STATUS_WORD));

        // ====================
        // Random mix
        // ====================
        for (int i = 0; i < MIX_TXN; i++) begin
            random_addr(addr);
            if ($random(seed) & 1) begin
                do_write(addr, $random(seed), STRB_W'($random(seed)));
            end else begin
                do_read(addr);
            end
        end

        @(negedge apb_if);
        apb_req = '0;
        repeat (4) @(posedge apb_if);
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/apb_reg_asserts.sv ====
`default_nettype none

`include "apb_reg_macros.svh"

module apb_reg_asserts #(
    parameter int DEPTH       = `REG_FIFO_DEPTH,
    parameter int OUT_CREDITS = 1
) (
    input wire logic                               apb_if,
    input wire logic                               arst_n,
    input wire logic                               in_valid,
    input wire logic                               in_credit,
    input wire logic                               out_valid,
    input wire logic                               out_credit,
    input wire logic [$clog2(DEPTH + 1)-1:0]       count,
    input wire logic [$clog2(OUT_CREDITS + 1)-1:0] out_crd
);
    localparam int HELD_W = $clog2(DEPTH + 1);
    localparam int CRD_W  = $clog2(OUT_CREDITS + 1);

    // Items pushed and not yet credited back upstream
    logic [HELD_W-1:0] held;
    // Downstream credits left, counted from valid and credit pulses
    logic [CRD_W-1:0]  crd_left;

    always_ff @(posedge apb_if or negedge arst_n) begin
        if (!arst_n) begin
            held     <= '0;
            crd_left <= CRD_W'(OUT_CREDITS);
        end else begin
            held     <= held + HELD_W'(in_valid) - HELD_W'(in_credit);
            crd_left <= crd_left - CRD_W'(out_valid) + CRD_W'(out_credit);
        end
    end

    // ====================
    // Occupancy
    // ====================
    // Upstream credits never allow a push past the last slot
    push_not_full: assert property (@(posedge apb_if) disable iff (!arst_n)
        in_valid |-> count < DEPTH)
        else $error("push into a full FIFO");

    // A freed slot needs an item to leave
    credit_not_empty: assert property (@(posedge apb_if) disable iff (!arst_n)
        in_credit |-> held != '0)
        else $error("upstream credit pulse while the FIFO is empty");

    // ====================
    // Downstream credits
    // ====================
    valid_has_credit: assert property (@(posedge apb_if) disable iff (!arst_n)
        out_valid |-> crd_left != '0)
        else $error("output valid without a downstream credit");

    // Returned credit matches an item already sent
    credit_in_bounds: assert property (@(posedge apb_if) disable iff (!arst_n)
        out_credit |-> out_crd < OUT_CREDITS)
        else $error("downstream credit returned beyond the credit limit");

endmodule

`default_nettype wire

// ==== source/apb_reg_top.sv ====
`default_nettype none

`include "apb_reg_macros.svh"

module apb_reg_top (
    input  wire logic                 apb_if,
    input  wire logic                 arst_n,
    input  wire apb_reg_pkg::apb_req_t apb_req,
    output apb_reg_pkg::apb_rsp_t      apb_rsp
);
    import apb_reg_pkg::*;

    // Bridge to request FIFO
    logic     bridge_req_valid;
    reg_req_t bridge_req;
    logic     bridge_req_credit;

    // Request FIFO to bank
    logic     bank_req_valid;
    reg_req_t bank_req;
    logic     bank_req_credit;

    // Bank to response FIFO
    logic     bank_rsp_valid;
    reg_rsp_t bank_rsp;
    logic     bank_rsp_credit;

    // Response FIFO to bridge
    logic     bridge_rsp_valid;
    reg_rsp_t bridge_rsp;
    logic     bridge_rsp_credit;

    // ====================
    // Producer
    // ====================
    apb_req_bridge bridge_i (
        .apb_if     (apb_if),
        .arst_n     (arst_n),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .req_valid  (bridge_req_valid),
        .req        (bridge_req),
        .req_credit (bridge_req_credit),
        .rsp_valid  (bridge_rsp_valid),
        .rsp        (bridge_rsp),
        .rsp_credit (bridge_rsp_credit)
    );

    // ====================
    // Buffers
    // ====================
    // Bank takes one request at a time
    credit_fifo #(
        .payload_t   (reg_req_t),
        .DEPTH       (`REG_FIFO_DEPTH),
        .OUT_CREDITS (1)
    ) req_fifo_i (
        .apb_if     (apb_if),
        .arst_n     (arst_n),
        .in_valid   (bridge_req_valid),
        .in_data    (bridge_req),
        .in_credit  (bridge_req_credit),
        .out_valid  (bank_req_valid),
        .out_data   (bank_req),
        .out_credit (bank_req_credit)
    );

    // Bridge holds a single response
    credit_fifo #(
        .payload_t   (reg_rsp_t),
        .DEPTH       (`REG_FIFO_DEPTH),
        .OUT_CREDITS (1)
    ) rsp_fifo_i (
        .apb_if     (apb_if),
        .arst_n     (arst_n),
        .in_valid   (bank_rsp_valid),
        .in_data    (bank_rsp),
        .in_credit  (bank_rsp_credit),
        .out_valid  (bridge_rsp_valid),
        .out_data   (bridge_rsp),
        .out_credit (bridge_rsp_credit)
    );

    // ====================
    // Consumer
    // ====================
    reg_bank bank_i (
        .apb_if     (apb_if),
        .arst_n     (arst_n),
        .req_valid  (bank_req_valid),
        .req        (bank_req),
        .req_credit (bank_req_credit),
        .rsp_valid  (bank_rsp_valid),
        .rsp        (bank_rsp),
        .rsp_credit (bank_rsp_credit)
    );

endmodule

`default_nettype wire

// ==== source/reg_bank.sv ====
`default_nettype none

`include "apb_reg_macros.svh"

module reg_bank (
    input  wire logic                 apb_if,
    input  wire logic                 arst_n,

    // Requests from the request FIFO
    input  wire logic                 req_valid,
    input  wire apb_reg_pkg::reg_req_t req,
    output logic                      req_credit,

    // Read results toward the response FIFO
    output logic                      rsp_valid,
    output apb_reg_pkg::reg_rsp_t      rsp,
    input  wire logic                 rsp_credit
);
    import apb_reg_pkg::*;

    localparam int IDX_W = $clog2(`REG_COUNT);
    localparam int CRD_W = $clog2(`REG_FIFO_DEPTH + 1);

    reg_req_t               slot_q;
    logic                   slot_full;
    logic [`APB_DATA_W-1:0] regs [`REG_COUNT];
    logic [`APB_DATA_W-1:0] drop_cnt;
    logic [CRD_W-1:0]       rsp_crd;
    logic [IDX_W-1:0]       idx;
    logic                   in_range;
    logic                   is_status;
    logic                   exec;

    // ====================
    // Decode and issue
    // ====================
    assign idx       = slot_q.addr[IDX_W-1:0];
    assign in_range  = slot_q.addr < `APB_ADDR_W'(`REG_COUNT);
    assign is_status = slot_q.addr == `APB_ADDR_W'(`REG_COUNT);

    // Reads stall until the response FIFO has room
    assign exec       = slot_full && (slot_q.write || rsp_crd != '0);
    assign req_credit = exec;
    assign rsp_valid  = exec && !slot_q.write;

    always_comb begin
        rsp = '0;
        if (in_range) begin
            rsp.rdata = regs[idx];
        end else if (is_status) begin
            rsp.rdata = drop_cnt;
        end else begin
            rsp.err = 1'b1;
        end
    end

    // Input slot
    always_ff @(posedge apb_if) begin
        if (req_valid) begin
            slot_q <= req;
        end
    end

    always_ff @(posedge apb_if or negedge arst_n) begin
        if (!arst_n) begin
            slot_full <= 1'b0;
        end else if (req_valid) begin
            slot_full <= 1'b1;
        end else if (exec) begin
            slot_full <= 1'b0;
        end
    end

    // ====================
    // Register state
    // ====================
    always_ff @(posedge apb_if or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            drop_cnt <= '0;
        end else if (exec && slot_q.write) begin
            if (in_range) begin
                for (int b = 0; b < `APB_STRB_W; b++) begin
                    if (slot_q.be[b]) begin
                        regs[idx][8*b +: 8] <= slot_q.wdata[8*b +: 8];
                    end
                end
            end else if (drop_cnt != '1) begin
                // Status or unmapped, counts as dropped
                drop_cnt <= drop_cnt + 1'b1;
            end
        end
    end

    // Response credits
    always_ff @(posedge apb_if or negedge arst_n) begin
        if (!arst_n) begin
            rsp_crd <= CRD_W'(`REG_FIFO_DEPTH);
        end else begin
            case ({rsp_valid, rsp_credit})
                2'b10:   rsp_crd <= rsp_crd - 1'b1;
                2'b01:   rsp_crd <= rsp_crd + 1'b1;
                default: rsp_crd <= rsp_crd;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/apb_req_bridge.sv ====
`default_nettype none

`include "apb_reg_macros.svh"

module apb_req_bridge (
    input  wire logic                 apb_if,
    input  wire logic                 arst_n,

    // APB completer side
    input  wire apb_reg_pkg::apb_req_t apb_req,
    output apb_reg_pkg::apb_rsp_t      apb_rsp,

    // Requests toward the bank
    output logic                      req_valid,
    output apb_reg_pkg::reg_req_t      req,
    input  wire logic                 req_credit,

    // Read results coming back
    input  wire logic                 rsp_valid,
    input  wire apb_reg_pkg::reg_rsp_t rsp,
    output logic                      rsp_credit
);
    import apb_reg_pkg::*;

    // ====================
    // Local types
    // ====================
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACC_WR,
        ST_ACC_RD,
        ST_RD_WAIT
    } state_t;

    localparam int CRD_W = $clog2(`REG_FIFO_DEPTH + 1);

    state_t           state;
    state_t           next_state;
    reg_req_t         req_q;
    reg_rsp_t         rsp_q;
    logic             rsp_full;
    logic [CRD_W-1:0] req_crd;
    logic             send;
    logic             done_rd;
    logic             setup;

    // Setup phase of a new transfer
    assign setup = apb_req.psel && !apb_req.penable;

    // ====================
    // Transfer FSM
    // ====================
    always_ff @(posedge apb_if or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        send       = 1'b0;
        done_rd    = 1'b0;
        apb_rsp    = '0;
        case (state)
            ST_IDLE: begin
                if (setup) begin
                    next_state = apb_req.pwrite ? ST_ACC_WR : ST_ACC_RD;
                end
            end
            ST_ACC_WR: begin
                // Posted write, pready together with the send
                if (apb_req.penable && req_crd != '0) begin
                    send           = 1'b1;
                    apb_rsp.pready = 1'b1;
                    next_state     = ST_IDLE;
                end
            end
            ST_ACC_RD: begin
                if (apb_req.penable && req_crd != '0) begin
                    send       = 1'b1;
                    next_state = ST_RD_WAIT;
                end
            end
            ST_RD_WAIT: begin
                if (rsp_full) begin
                    done_rd         = 1'b1;
                    apb_rsp.pready  = 1'b1;
                    apb_rsp.pslverr = rsp_q.err;
                    apb_rsp.prdata  = rsp_q.rdata;
                    next_state      = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // Capture in setup, word address only
    always_ff @(posedge apb_if) begin
        if (state == ST_IDLE && setup) begin
            req_q.write <= apb_req.pwrite;
            req_q.addr  <= {2'b00, apb_req.paddr[`APB_ADDR_W-1:2]};
            req_q.wdata <= apb_req.pwdata;
            req_q.be    <= apb_req.pstrb;
        end
    end

    assign req_valid = send;
    assign req       = req_q;

    // ====================
    // Credits and response
    // ====================
    always_ff @(posedge apb_if or negedge arst_n) begin
        if (!arst_n) begin
            req_crd <= CRD_W'(`REG_FIFO_DEPTH);
        end else begin
            case ({send, req_credit})
                2'b10:   req_crd <= req_crd - 1'b1;
                2'b01:   req_crd <= req_crd + 1'b1;
                default: req_crd <= req_crd;
            endcase
        end
    end

    // Single response slot
    always_ff @(posedge apb_if) begin
        if (rsp_valid) begin
            rsp_q <= rsp;
        end
    end

    // Slot freed by the completing read, credit goes back a cycle later
    always_ff @(posedge apb_if or negedge arst_n) begin
        if (!arst_n) begin
            rsp_full   <= 1'b0;
            rsp_credit <= 1'b0;
        end else begin
            rsp_credit <= done_rd;
            if (rsp_valid) begin
                rsp_full <= 1'b1;
            end else if (done_rd) begin
                rsp_full <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/credit_fifo.sv ====
`default_nettype none

`include "apb_reg_macros.svh"

module credit_fifo #(
    parameter type payload_t   = apb_reg_pkg::reg_req_t,
    parameter int  DEPTH       = `REG_FIFO_DEPTH,
    parameter int  OUT_CREDITS = 1
) (
    input  wire logic     apb_if,
    input  wire logic     arst_n,

    // Upstream, one credit per free slot
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          in_credit,

    // Downstream
    output logic          out_valid,
    output payload_t      out_data,
    input  wire logic     out_credit
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int CRD_W = $clog2(OUT_CREDITS + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] out_crd;
    logic             pop;

    // Head leaves as soon as downstream has room
    assign pop       = (count != '0) && (out_crd != '0);
    assign out_valid = pop;
    assign out_data  = mem[rd_ptr];
    assign in_credit = pop;

    // ====================
    // Storage
    // ====================
    always_ff @(posedge apb_if) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge apb_if or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // ====================
    // Occupancy and credits
    // ====================
    always_ff @(posedge apb_if or negedge arst_n) begin
        if (!arst_n) begin
            count   <= '0;
            out_crd <= CRD_W'(OUT_CREDITS);
        end else begin
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({pop, out_credit})
                2'b10:   out_crd <= out_crd - 1'b1;
                2'b01:   out_crd <= out_crd + 1'b1;
                default: out_crd <= out_crd;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/apb_reg_pkg.sv ====
`default_nettype none

`include "apb_reg_macros.svh"

package apb_reg_pkg;

    // ====================
    // APB side
    // ====================

    // Master to completer
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [`APB_DATA_W-1:0] pwdata;
        logic [`APB_STRB_W-1:0] pstrb;
    } apb_req_t;

    // Completer to master
    typedef struct packed {
        logic                   pready;
        logic                   pslverr;
        logic [`APB_DATA_W-1:0] prdata;
    } apb_rsp_t;

    // ====================
    // Register link
    // ====================

    // Bridge to bank, through the request FIFO
    // Word address, already shifted down by two
    typedef struct packed {
        logic                   write;
        logic [`APB_ADDR_W-1:0] addr;
        logic [`APB_DATA_W-1:0] wdata;
        logic [`APB_STRB_W-1:0] be;
    } reg_req_t;

    // Bank to bridge, reads only
    typedef struct packed {
        logic [`APB_DATA_W-1:0] rdata;
        logic                   err;
    } reg_rsp_t;

endpackage

`default_nettype wire

// ==== include/apb_reg_macros.svh ====
`ifndef APB_REG_MACROS_SVH
`define APB_REG_MACROS_SVH

// ====================
// APB bus widths
// ====================
`define APB_ADDR_W 12
`define APB_DATA_W 32

// One strobe bit per data byte
`define APB_STRB_W (`APB_DATA_W / 8)

// ====================
// Register path sizing
// ====================
// Slots in each credit FIFO
`define REG_FIFO_DEPTH 4

// Read/write registers; status sits right above them
`define REG_COUNT 8

`endif
